// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN   = 32;
    localparam int PREG_W = 6;
    localparam int ROB_W  = 5;

    // Physical tag 0 is the hard-wired zero register
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [ROB_W-1:0]  rob_tag_t;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    // Branch funct3 encodings
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [1:0] {
        src1_rs1 = 2'b00,
        src1_imm = 2'b01,
        src1_pc  = 2'b11
    } src1_sel_t;

    typedef enum logic [1:0] {
        src2_rs2  = 2'b00,
        src2_zero = 2'b01,
        src2_imm  = 2'b11
    } src2_sel_t;

    typedef enum logic [2:0] {
        kind_arith   = 3'd0,
        kind_compare = 3'd1,
        kind_branch  = 3'd2,
        kind_jal     = 3'd3,
        kind_jalr    = 3'd4
    } inst_kind_t;

    typedef struct packed {
        inst_kind_t      kind;
        alu_op_t         alu_op;
        cmp_op_t         cmp_op;
        src1_sel_t       src1_sel;
        src2_sel_t       src2_sel;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        rob_tag_t        rob_tag;
        preg_t           rs1;
        preg_t           rs2;
        preg_t           rd;
    } fu_inst_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        rob_tag;
        preg_t           rd;
        logic [XLEN-1:0] value;
        logic            taken;
        logic [XLEN-1:0] pc_next;
    } wb_t;

    // Branches feed rs1 and rs2 to the comparator whatever the ALU selects
    function automatic logic needs_rs1(input fu_inst_t inst);
        return (inst.src1_sel == src1_rs1) || (inst.kind == kind_branch);
    endfunction

    function automatic logic needs_rs2(input fu_inst_t inst);
        return (inst.src2_sel == src2_rs2) || (inst.kind == kind_branch);
    endfunction

endpackage

`default_nettype wire

// File: verilog/alu.sv
`default_nettype none

module alu (
    input  exec_pkg::alu_op_t aluop,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       f
);
    import exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << shamt;
            alu_slt:  f = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: f = {31'd0, a < b};
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:  f = $unsigned($signed(a) >>> shamt);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/cmp.sv
`default_nettype none

module cmp (
    input  exec_pkg::cmp_op_t cmpop,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic              br_en
);
    import exec_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (cmpop)
            cmp_beq:  br_en = eq;
            cmp_bne:  br_en = !eq;
            cmp_blt:  br_en = lt_s;
            cmp_bge:  br_en = !lt_s;
            cmp_bltu: br_en = lt_u;
            cmp_bgeu: br_en = !lt_u;
            default:  br_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/phys_regfile.sv
`default_nettype none

module phys_regfile #(
    parameter int PHYS_REGS = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  exec_pkg::preg_t      rs1,
    input  exec_pkg::preg_t      rs2,
    output logic [31:0]          rs1_value,
    output logic [31:0]          rs2_value,
    output logic                 rs1_ready,
    output logic                 rs2_ready,
    output logic [PHYS_REGS-1:0] ready_mask,
    input  logic                 busy_valid,
    input  exec_pkg::preg_t      busy_tag,
    input  exec_pkg::wb_t        wb
);

    logic [31:0]          regs_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;
    logic                 wr_en;

    assign wr_en = wb.valid && (wb.rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb.rd] <= wb.value;
        end
    end

    // Busy mark comes last so it wins over a same-cycle writeback
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= '1;
        end else if (flush) begin
            ready_q <= '1;
        end else begin
            if (wr_en) begin
                ready_q[wb.rd] <= 1'b1;
            end
            if (busy_valid && (busy_tag != '0)) begin
                ready_q[busy_tag] <= 1'b0;
            end
        end
    end

    // Zero register reads as 0 and is always ready
    assign ready_mask = {ready_q[PHYS_REGS-1:1], 1'b1};
    assign rs1_value  = (rs1 == '0) ? '0 : regs_q[rs1];
    assign rs2_value  = (rs2 == '0) ? '0 : regs_q[rs2];
    assign rs1_ready  = ready_mask[rs1];
    assign rs2_ready  = ready_mask[rs2];

    a_tag_range: assert property (@(posedge clk) disable iff (!arst_n)
        (busy_valid |-> busy_tag < PHYS_REGS) and (wb.valid |-> wb.rd < PHYS_REGS))
        else $error("physical tag out of range");

endmodule

`default_nettype wire

// File: verilog/alu_station.sv
`default_nettype none

module alu_station #(
    parameter int DEPTH     = 4,
    parameter int PHYS_REGS = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 dispatch_valid,
    input  exec_pkg::fu_inst_t   dispatch_inst,
    output logic                 space,
    input  exec_pkg::wb_t        wb,
    input  logic [PHYS_REGS-1:0] ready_mask,
    output logic                 issue_valid,
    output exec_pkg::fu_inst_t   issue_inst
);
    import exec_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Entry 0 is the oldest; valid entries stay packed from the bottom
    fu_inst_t         ent_q [DEPTH];
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0] rdy1_q;
    logic [DEPTH-1:0] rdy2_q;

    // After wakeup, with one empty slot on top to shift in from
    fu_inst_t         ent_w [DEPTH+1];
    logic [DEPTH:0]   valid_w;
    logic [DEPTH:0]   rdy1_w;
    logic [DEPTH:0]   rdy2_w;

    fu_inst_t         ent_n [DEPTH];
    logic [DEPTH-1:0] valid_n;
    logic [DEPTH-1:0] rdy1_n;
    logic [DEPTH-1:0] rdy2_n;

    logic             issue_found;
    logic [IDX_W-1:0] issue_idx;
    logic             disp_rdy1;
    logic             disp_rdy2;
    logic             placed;

    function automatic logic woken(input logic rdy, input preg_t tag, input wb_t w);
        return rdy || (w.valid && (w.rd == tag));
    endfunction

    // Oldest entry with both sources ready
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!issue_found && valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
                issue_found = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    assign issue_valid = issue_found && !flush;
    assign issue_inst  = ent_q[issue_idx];
    assign space       = !valid_q[DEPTH-1];

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_w[i]   = ent_q[i];
            valid_w[i] = valid_q[i];
            rdy1_w[i]  = woken(rdy1_q[i], ent_q[i].rs1, wb);
            rdy2_w[i]  = woken(rdy2_q[i], ent_q[i].rs2, wb);
        end
        ent_w[DEPTH]   = '0;
        valid_w[DEPTH] = 1'b0;
        rdy1_w[DEPTH]  = 1'b0;
        rdy2_w[DEPTH]  = 1'b0;
    end

    // A writeback in the dispatch cycle is not yet in ready_mask
    assign disp_rdy1 = !needs_rs1(dispatch_inst)
        || woken(ready_mask[dispatch_inst.rs1], dispatch_inst.rs1, wb);
    assign disp_rdy2 = !needs_rs2(dispatch_inst)
        || woken(ready_mask[dispatch_inst.rs2], dispatch_inst.rs2, wb);

    // Close the gap left by the issued entry, then append at the first free slot
    always_comb begin
        placed = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (issue_valid && (i >= int'(issue_idx))) begin
                ent_n[i]   = ent_w[i+1];
                valid_n[i] = valid_w[i+1];
                rdy1_n[i]  = rdy1_w[i+1];
                rdy2_n[i]  = rdy2_w[i+1];
            end else begin
                ent_n[i]   = ent_w[i];
                valid_n[i] = valid_w[i];
                rdy1_n[i]  = rdy1_w[i];
                rdy2_n[i]  = rdy2_w[i];
            end
            if (dispatch_valid && !placed && !valid_n[i]) begin
                ent_n[i]   = dispatch_inst;
                valid_n[i] = 1'b1;
                rdy1_n[i]  = disp_rdy1;
                rdy2_n[i]  = disp_rdy2;
                placed     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            rdy1_q  <= '0;
            rdy2_q  <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_n;
            rdy1_q  <= rdy1_n;
            rdy2_q  <= rdy2_n;
        end
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_n;
    end

    a_no_dispatch_full: assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_valid && !flush |-> space)
        else $error("dispatch into a full station");

    // A hole below a valid entry would break oldest-first issue and the space flag
    a_entries_packed: assert property (@(posedge clk) disable iff (!arst_n)
        ((valid_q + 1'b1) & valid_q) == '0)
        else $error("station entries not packed from the bottom");

endmodule

`default_nettype wire

// File: verilog/alu_fu.sv
`default_nettype none

module alu_fu (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               issue_valid,
    input  exec_pkg::fu_inst_t issue_inst,
    input  logic [31:0]        rs1_value,
    input  logic [31:0]        rs2_value,
    output exec_pkg::wb_t      wb
);
    import exec_pkg::*;

    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] cmp_a;
    logic [31:0] cmp_b;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic        cmp_res;
    wb_t         wb_d;
    wb_t         wb_q;

    // U-type is imm + 0, branches and jumps put pc or rs1 plus imm through the ALU
    always_comb begin
        case (issue_inst.src1_sel)
            src1_rs1: alu_a = rs1_value;
            src1_imm: alu_a = issue_inst.imm;
            src1_pc:  alu_a = issue_inst.pc;
            default:  alu_a = '0;
        endcase
        case (issue_inst.src2_sel)
            src2_rs2:  alu_b = rs2_value;
            src2_zero: alu_b = '0;
            src2_imm:  alu_b = issue_inst.imm;
            default:   alu_b = '0;
        endcase
    end

    // Comparator sees the registers on branches, the ALU inputs for set-less-than
    assign cmp_a = (issue_inst.kind == kind_branch) ? rs1_value : alu_a;
    assign cmp_b = (issue_inst.kind == kind_branch) ? rs2_value : alu_b;

    alu u_alu (
        .aluop (issue_inst.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_res)
    );

    cmp u_cmp (
        .cmpop (issue_inst.cmp_op),
        .a     (cmp_a),
        .b     (cmp_b),
        .br_en (cmp_res)
    );

    assign pc_plus4 = issue_inst.pc + 32'd4;

    always_comb begin
        wb_d         = '0;
        wb_d.valid   = issue_valid;
        wb_d.rob_tag = issue_inst.rob_tag;
        wb_d.rd      = issue_inst.rd;
        wb_d.pc_next = pc_plus4;
        case (issue_inst.kind)
            kind_branch: begin
                wb_d.rd      = '0;
                wb_d.taken   = cmp_res;
                wb_d.pc_next = cmp_res ? alu_res : pc_plus4;
            end
            kind_jal: begin
                wb_d.value   = pc_plus4;
                wb_d.taken   = 1'b1;
                wb_d.pc_next = alu_res;
            end
            kind_jalr: begin
                wb_d.value   = pc_plus4;
                wb_d.taken   = 1'b1;
                wb_d.pc_next = {alu_res[31:1], 1'b0};
            end
            kind_compare: wb_d.value = {31'd0, cmp_res};
            default:      wb_d.value = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else if (flush) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    // Result of the flush cycle must not reach the register file
    always_comb begin
        wb = wb_q;
        if (flush) begin
            wb.valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_top.sv
`default_nettype none

module exec_top #(
    parameter int PHYS_REGS = 64,
    parameter int DEPTH     = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,
    input  logic               dispatch_valid,
    input  exec_pkg::fu_inst_t dispatch_inst,
    output logic               space,
    output exec_pkg::wb_t      wb
);
    import exec_pkg::*;

    logic                 issue_valid;
    fu_inst_t             issue_inst;
    logic [31:0]          rs1_value;
    logic [31:0]          rs2_value;
    logic                 rs1_ready;
    logic                 rs2_ready;
    logic [PHYS_REGS-1:0] ready_mask;

    alu_station #(
        .DEPTH     (DEPTH),
        .PHYS_REGS (PHYS_REGS)
    ) u_alu_station (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .space          (space),
        .wb             (wb),
        .ready_mask     (ready_mask),
        .issue_valid    (issue_valid),
        .issue_inst     (issue_inst)
    );

    // Dispatch marks the destination busy
    phys_regfile #(
        .PHYS_REGS (PHYS_REGS)
    ) u_phys_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .rs1        (issue_inst.rs1),
        .rs2        (issue_inst.rs2),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready),
        .ready_mask (ready_mask),
        .busy_valid (dispatch_valid),
        .busy_tag   (dispatch_inst.rd),
        .wb         (wb)
    );

    alu_fu u_alu_fu (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_inst  (issue_inst),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .wb          (wb)
    );

    // Station copies of the ready bits must agree with the register file at issue
    a_issue_operands_ready: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid |-> (rs1_ready || !needs_rs1(issue_inst))
                     && (rs2_ready || !needs_rs2(issue_inst)))
        else $error("issued with a busy source register");

endmodule

`default_nettype wire

// File: bench/exec_tb.sv
`default_nettype none

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic     clk;
    logic     arst_n;
    logic     flush;
    logic     dispatch_valid;
    fu_inst_t dispatch_inst;
    logic     space;
    wb_t      wb;

    // Reference model state
    logic [31:0] model_regs [64];
    wb_t         exp_wb [32];
    inst_kind_t  exp_kind [32];
    rob_tag_t    next_rob;
    logic        saw_full;

    // A ROB tag is in flight while its issued and retired bits differ
    logic [31:0] issued  = '0;
    logic [31:0] retired = '0;

    alu_op_t all_ops [10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                              alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    cmp_op_t all_conds [6] = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};

    exec_top #(
        .PHYS_REGS (64),
        .DEPTH     (4)
    ) u_exec_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .space          (space),
        .wb             (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("** Error at %0t: %s = 0x%08h, expected 0x%08h",
                                        $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] reg_value(input preg_t tag);
        return (tag == '0) ? 32'd0 : model_regs[tag];
    endfunction

    function automatic logic [31:0] ref_alu(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return 32'($signed(a) >>> b[4:0]);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic ref_cond(input cmp_op_t op, input logic [31:0] a,
                                      input logic [31:0] b);
        case (op)
            cmp_beq:  return a == b;
            cmp_bne:  return a != b;
            cmp_blt:  return $signed(a) < $signed(b);
            cmp_bge:  return $signed(a) >= $signed(b);
            cmp_bltu: return a < b;
            cmp_bgeu: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    // Expected writeback record for one instruction, from the model registers
    function automatic wb_t predict_wb(input fu_inst_t inst);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic        cond;
        wb_t         res;
        r1 = reg_value(inst.rs1);
        r2 = reg_value(inst.rs2);
        case (inst.src1_sel)
            src1_rs1: op_a = r1;
            src1_imm: op_a = inst.imm;
            default:  op_a = inst.pc;
        endcase
        case (inst.src2_sel)
            src2_rs2: op_b = r2;
            src2_imm: op_b = inst.imm;
            default:  op_b = 32'd0;
        endcase
        res         = '0;
        res.valid   = 1'b1;
        res.rob_tag = inst.rob_tag;
        res.rd      = inst.rd;
        res.pc_next = inst.pc + 32'd4;
        case (inst.kind)
            kind_compare: res.value = {31'd0, ref_cond(inst.cmp_op, op_a, op_b)};
            kind_branch: begin
                cond      = ref_cond(inst.cmp_op, r1, r2);
                res.rd    = '0;
                res.taken = cond;
                if (cond) begin
                    res.pc_next = inst.pc + inst.imm;
                end
            end
            kind_jal: begin
                res.value   = inst.pc + 32'd4;
                res.taken   = 1'b1;
                res.pc_next = inst.pc + inst.imm;
            end
            kind_jalr: begin
                res.value   = inst.pc + 32'd4;
                res.taken   = 1'b1;
                res.pc_next = (r1 + inst.imm) & 32'hFFFF_FFFE;
            end
            default: res.value = ref_alu(inst.alu_op, op_a, op_b);
        endcase
        return res;
    endfunction

    function automatic fu_inst_t make_inst(input inst_kind_t kind, input alu_op_t aop,
                                           input cmp_op_t cop, input src1_sel_t s1,
                                           input src2_sel_t s2, input logic [31:0] imm,
                                           input preg_t rs1, input preg_t rs2,
                                           input preg_t rd);
        fu_inst_t inst;
        inst          = '0;
        inst.kind     = kind;
        inst.alu_op   = aop;
        inst.cmp_op   = cop;
        inst.src1_sel = s1;
        inst.src2_sel = s2;
        inst.imm      = imm;
        inst.pc       = $urandom & 32'hFFFF_FFFC;
        inst.rs1      = rs1;
        inst.rs2      = rs2;
        inst.rd       = rd;
        return inst;
    endfunction

    task automatic wait_for_space();
        int cycles;
        cycles = 0;
        while (!space) begin
            saw_full = 1'b1;
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timeout: station space never returned high");
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (issued != retired) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Timeout: expected writebacks did not all arrive");
            end
        end
    endtask

    // Without expect_result the instruction is left out of the model
    task automatic dispatch_one(input fu_inst_t inst, input logic expect_result);
        wait_for_space();
        if (issued[next_rob] != retired[next_rob]) begin
            stop_with_failure("ROB tag reused while its instruction is still in flight");
        end
        inst.rob_tag = next_rob;
        if (expect_result) begin
            exp_wb[next_rob]   = predict_wb(inst);
            exp_kind[next_rob] = inst.kind;
            issued[next_rob]   = ~issued[next_rob];
            if (inst.kind != kind_branch && inst.rd != '0) begin
                model_regs[inst.rd] = exp_wb[next_rob].value;
            end
        end
        next_rob++;
        dispatch_valid = 1'b1;
        dispatch_inst  = inst;
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    // U-type style load, imm + 0
    task automatic load_const(input preg_t rd, input logic [31:0] value);
        dispatch_one(make_inst(kind_arith, alu_add, cmp_beq, src1_imm, src2_zero, value,
                               '0, '0, rd), 1'b1);
    endtask

    task automatic alu_op_sweep();
        for (int i = 1; i <= 8; i++) begin
            load_const(preg_t'(i), $urandom);
        end
        for (int k = 0; k < 10; k++) begin
            dispatch_one(make_inst(kind_arith, all_ops[k], cmp_beq, src1_rs1, src2_rs2, 32'd0,
                                   preg_t'(1 + k % 8), preg_t'(1 + (k + 3) % 8),
                                   preg_t'(16 + k)), 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            dispatch_one(make_inst(kind_arith, all_ops[k], cmp_beq, src1_rs1, src2_imm,
                                   $urandom, preg_t'(1 + k % 8), '0, preg_t'(32 + k)), 1'b1);
        end
        wait_drain();
    endtask

    task automatic set_less_than_cases();
        load_const(preg_t'(1), 32'hFFFF_FFFF);
        load_const(preg_t'(2), 32'h0000_0001);
        load_const(preg_t'(3), 32'h8000_0000);
        load_const(preg_t'(4), 32'h7FFF_FFFF);
        for (int k = 1; k <= 4; k++) begin
            for (int j = 1; j <= 4; j++) begin
                dispatch_one(make_inst(kind_compare, alu_slt, cmp_blt, src1_rs1, src2_rs2,
                                       32'd0, preg_t'(k), preg_t'(j),
                                       preg_t'(8 + 4 * k + j)), 1'b1);
                dispatch_one(make_inst(kind_compare, alu_sltu, cmp_bltu, src1_rs1, src2_rs2,
                                       32'd0, preg_t'(k), preg_t'(j),
                                       preg_t'(32 + 4 * k + j)), 1'b1);
            end
        end
        // Immediate form, negative immediate against a small positive
        dispatch_one(make_inst(kind_compare, alu_slt, cmp_blt, src1_rs1, src2_imm,
                               32'hFFFF_FFF0, preg_t'(2), '0, preg_t'(60)), 1'b1);
        dispatch_one(make_inst(kind_compare, alu_sltu, cmp_bltu, src1_rs1, src2_imm,
                               32'hFFFF_FFF0, preg_t'(2), '0, preg_t'(61)), 1'b1);
        wait_drain();
    endtask

    // Uses the edge values still held in tags 1 to 4
    task automatic branch_conditions();
        for (int c = 0; c < 6; c++) begin
            for (int k = 1; k <= 4; k++) begin
                for (int j = 1; j <= 4; j++) begin
                    dispatch_one(make_inst(kind_branch, alu_add, all_conds[c], src1_pc,
                                           src2_imm, $urandom & 32'h0000_1FFE,
                                           preg_t'(k), preg_t'(j), '0), 1'b1);
                end
            end
        end
        wait_drain();
    endtask

    task automatic jump_targets();
        load_const(preg_t'(5), 32'h1000_0003);
        dispatch_one(make_inst(kind_jal, alu_add, cmp_beq, src1_pc, src2_imm,
                               $urandom & 32'h000F_FFFE, '0, '0, preg_t'(20)), 1'b1);
        dispatch_one(make_inst(kind_jalr, alu_add, cmp_beq, src1_rs1, src2_imm,
                               32'h0000_0010, preg_t'(5), '0, preg_t'(21)), 1'b1);
        dispatch_one(make_inst(kind_jalr, alu_add, cmp_beq, src1_rs1, src2_imm,
                               32'hFFFF_FFFD, preg_t'(5), '0, preg_t'(22)), 1'b1);
        wait_drain();
    endtask

    // Each link needs the previous result, so the station backs up
    task automatic dependency_chain();
        saw_full = 1'b0;
        load_const(preg_t'(40), $urandom);
        for (int k = 0; k < 12; k++) begin
            dispatch_one(make_inst(kind_arith, all_ops[k % 10], cmp_beq, src1_rs1, src2_rs2,
                                   32'd0, preg_t'(40 + k), preg_t'(1), preg_t'(41 + k)),
                         1'b1);
        end
        wait_drain();
        check_value("space_dropped", 32'(saw_full), 32'd1);
        check_value("space", 32'(space), 32'd1);
    endtask

    // A three-link chain delays the producer of tag 50 until its consumers fill the station
    task automatic flush_recovery();
        load_const(preg_t'(50), $urandom);
        wait_drain();
        load_const(preg_t'(56), $urandom);
        for (int k = 0; k < 2; k++) begin
            dispatch_one(make_inst(kind_arith, alu_add, cmp_beq, src1_rs1, src2_zero, 32'd0,
                                   preg_t'(56 + k), '0, preg_t'(57 + k)), 1'b1);
        end
        // Producer of tag 50 and the consumers that see it busy, all killed by the flush
        dispatch_one(make_inst(kind_arith, alu_add, cmp_beq, src1_rs1, src2_zero, 32'd0,
                               preg_t'(58), '0, preg_t'(50)), 1'b0);
        for (int k = 0; k < 3; k++) begin
            dispatch_one(make_inst(kind_arith, alu_add, cmp_beq, src1_rs1, src2_zero, 32'd0,
                                   preg_t'(50), '0, preg_t'(59 + k)), 1'b0);
        end
        check_value("space", 32'(space), 32'd0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (6) @(negedge clk);
        check_value("space", 32'(space), 32'd1);
        dispatch_one(make_inst(kind_arith, alu_add, cmp_beq, src1_rs1, src2_rs2, 32'd0,
                               preg_t'(50), '0, preg_t'(52)), 1'b1);
        wait_drain();
    endtask

    // Writeback monitor, sampled with the values the register file sees
    always @(posedge clk) begin
        if (arst_n && wb.valid) begin
            if (issued[wb.rob_tag] == retired[wb.rob_tag]) begin
                stop_with_failure($sformatf("Unexpected writeback for ROB tag %0d at %0t",
                                            wb.rob_tag, $time));
            end else begin
                retired[wb.rob_tag] = ~retired[wb.rob_tag];
                check_value("wb.rd", 32'(wb.rd), 32'(exp_wb[wb.rob_tag].rd));
                check_value("wb.value", wb.value, exp_wb[wb.rob_tag].value);
                if (exp_kind[wb.rob_tag] inside {kind_branch, kind_jal, kind_jalr}) begin
                    check_value("wb.taken", 32'(wb.taken), 32'(exp_wb[wb.rob_tag].taken));
                    check_value("wb.pc_next", wb.pc_next, exp_wb[wb.rob_tag].pc_next);
                end
            end
        end
    end

    initial begin
        void'($urandom(47975));
        arst_n         = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_inst  = '0;
        next_rob       = '0;
        saw_full       = 1'b0;
        for (int i = 0; i < 64; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        check_value("space", 32'(space), 32'd1);
        check_value("wb.valid", 32'(wb.valid), 32'd0);

        alu_op_sweep();
        set_less_than_cases();
        branch_conditions();
        jump_targets();
        dependency_chain();
        flush_recovery();

        if (issued == retired) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("Writebacks still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: src.f
verilog/exec_pkg.sv
verilog/alu.sv
verilog/cmp.sv
verilog/phys_regfile.sv
verilog/alu_station.sv
verilog/alu_fu.sv
verilog/exec_top.sv
bench/exec_tb.sv

// File: Makefile
TOP := exec_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
